// ==== bench/mini_subsystem_sva.sv ====
module mini_subsystem_sva (
    input logic clk_i,
    input logic rst_n_i,
    mem_bus_if  instr_bus,
    mem_bus_if  data_bus,
    input logic exit_valid_i,
    input logic tests_passed_i,
    input logic tests_failed_i
);

    // number of assertion failures so far
    int fail_count = 0;

    // a request waiting for its grant keeps its address
    instr_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_bus.req && !instr_bus.gnt |=> $stable(instr_bus.addr))
    else begin
        $error("instruction address changed while its request waited");
        fail_count++;
    end

    data_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_bus.req && !data_bus.gnt |=> $stable(data_bus.addr))
    else begin
        $error("data address changed while its request waited");
        fail_count++;
    end

    // rvalid is high exactly in the cycle after an accepted transfer
    instr_rvalid_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_bus.rvalid == $past(instr_bus.req && instr_bus.gnt))
    else begin
        $error("instruction rvalid does not follow acceptance by one cycle");
        fail_count++;
    end

    data_rvalid_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_bus.rvalid == $past(data_bus.req && data_bus.gnt))
    else begin
        $error("data rvalid does not follow acceptance by one cycle");
        fail_count++;
    end

    // an exit raises exactly one of the two result flags
    exit_one_flag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exit_valid_i |-> (tests_passed_i != tests_failed_i))
    else begin
        $error("exit without exactly one of the passed and failed flags");
        fail_count++;
    end

endmodule

bind mini_tb_subsystem mini_subsystem_sva sva_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .instr_bus      ( instr_bus      ),
    .data_bus       ( data_bus       ),
    .exit_valid_i   ( exit_valid_o   ),
    .tests_passed_i ( tests_passed_o ),
    .tests_failed_i ( tests_failed_o )
);

// ==== bench/tb_mini_subsystem.sv ====
`include "mini_settings.svh"

module tb_mini_subsystem import mini_pkg::*; ();

    localparam int RAM_WORDS      = 2 ** `MINI_RAM_ADDR_WIDTH;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int MODEL_STEPS    = 5000;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     fetch_enable;
    logic     load_we;
    ram_idx_t load_addr;
    word_t    load_data;
    logic     tests_passed;
    logic     tests_failed;
    word_t    exit_value;
    logic     exit_valid;

    word_t    prog [$];
    word_t    model_mem [RAM_WORDS];
    int       err_count = 0;
    int       test_count = 0;

    mini_tb_subsystem UUT (
        .clk_i          ( clk          ),
        .rst_n_i        ( rst_n        ),
        .fetch_enable_i ( fetch_enable ),
        .load_we_i      ( load_we      ),
        .load_addr_i    ( load_addr    ),
        .load_data_i    ( load_data    ),
        .tests_passed_o ( tests_passed ),
        .tests_failed_o ( tests_failed ),
        .exit_value_o   ( exit_value   ),
        .exit_valid_o   ( exit_valid   )
    );

    always #5 clk = ~clk;

    task automatic check_value(input string sig, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %08h, expected %08h", sig, got, exp);
            err_count++;
        end
    endtask

    function automatic word_t encode_instr(opcode_t op, int rd, int rs1, int rs2,
                                           logic [15:0] imm);
        return {op, rd[1:0], rs1[1:0], rs2[1:0], 6'b000000, imm};
    endfunction

    function automatic opcode_t pick_alu_op(logic allow_li);
        case ($urandom_range(allow_li ? 3 : 2, 0))
            0:       return OP_ADD;
            1:       return OP_SUB;
            2:       return OP_XOR;
            default: return OP_LI;
        endcase
    endfunction

    // r3 is built up to the exit address by doubling, then src is stored there
    task automatic append_exit(input int src);
        prog.push_back(encode_instr(OP_LI, 3, 0, 0, 16'(`MINI_EXIT_ADDR >> 16)));
        repeat (16) prog.push_back(encode_instr(OP_ADD, 3, 3, 3, 16'h0000));
        prog.push_back(encode_instr(OP_SW, 0, 3, src, 16'(`MINI_EXIT_ADDR)));
    endtask

    task automatic gen_body(input int n);
        prog.delete();
        for (int r = 0; r < 3; r++) begin
            prog.push_back(encode_instr(OP_LI, r, 0, 0, 16'($urandom())));
        end
        for (int i = 0; i < n; i++) begin
            prog.push_back(encode_instr(pick_alu_op(1'b1), $urandom_range(2, 0),
                $urandom_range(2, 0), $urandom_range(2, 0), 16'($urandom())));
        end
    endtask

    // stores go to the upper half of the RAM and are read back in reverse order
    task automatic gen_mem_program(input int k);
        int idx [$];
        prog.delete();
        prog.push_back(encode_instr(OP_LI, 1, 0, 0, 16'h0000));
        prog.push_back(encode_instr(OP_LI, 2, 0, 0, 16'($urandom())));
        for (int i = 0; i < k; i++) begin
            idx.push_back($urandom_range(RAM_WORDS - 1, RAM_WORDS / 2));
            prog.push_back(encode_instr(OP_LI, 0, 0, 0, 16'($urandom())));
            prog.push_back(encode_instr(OP_SW, 0, 1, 0, 16'(idx[i] * 4)));
        end
        for (int i = k - 1; i >= 0; i--) begin
            prog.push_back(encode_instr(OP_LW, 0, 1, 0, 16'(idx[i] * 4)));
            prog.push_back(encode_instr(pick_alu_op(1'b0), 2, 2, 0, 16'h0000));
        end
        append_exit(2);
    endtask

    task automatic gen_loop(input int count, input logic [15:0] step);
        prog.delete();
        prog.push_back(encode_instr(OP_LI, 0, 0, 0, 16'(count)));
        prog.push_back(encode_instr(OP_LI, 1, 0, 0, step));
        prog.push_back(encode_instr(OP_LI, 2, 0, 0, 16'h0000));
        prog.push_back(encode_instr(OP_LI, 3, 0, 0, 16'h0001));
        prog.push_back(encode_instr(OP_ADD, 2, 2, 1, 16'h0000));
        prog.push_back(encode_instr(OP_SUB, 0, 0, 3, 16'h0000));
        // back two words to the ADD while r0 is not zero
        prog.push_back(encode_instr(OP_BNEZ, 0, 0, 0, 16'hfffe));
        append_exit(2);
    endtask

    function automatic logic in_ram(addr_t a);
        return (a >> (`MINI_RAM_ADDR_WIDTH + 2)) == '0;
    endfunction

    function automatic word_t read_word(addr_t a);
        if (!in_ram(a)) begin
            return '0;
        end
        return model_mem[a[`MINI_RAM_ADDR_WIDTH+1:2]];
    endfunction

    // instruction set model running the loaded program on its own copy of the RAM
    task automatic model_run(output word_t result, output logic finished);
        word_t      regs [4];
        addr_t      pc;
        word_t      instr;
        word_t      sext;
        addr_t      ea;
        word_t      a;
        word_t      b;
        logic [1:0] rd;
        int         steps;
        regs = '{default: '0};
        pc = `MINI_BOOT_ADDR;
        result = '0;
        finished = 1'b0;
        steps = 0;
        while (!finished && steps < MODEL_STEPS) begin
            instr = read_word(pc);
            rd    = instr[27:26];
            a     = regs[instr[25:24]];
            b     = regs[instr[23:22]];
            sext  = {{16{instr[15]}}, instr[15:0]};
            ea    = {16'h0000, instr[15:0]} + a;
            pc    = pc + 4;
            case (instr[31:28])
                OP_LI:  regs[rd] = sext;
                OP_ADD: regs[rd] = a + b;
                OP_SUB: regs[rd] = a - b;
                OP_XOR: regs[rd] = a ^ b;
                OP_LW:  regs[rd] = read_word(ea);
                OP_SW: begin
                    if (ea == `MINI_EXIT_ADDR) begin
                        result = b;
                        finished = 1'b1;
                    end else if (in_ram(ea)) begin
                        model_mem[ea[`MINI_RAM_ADDR_WIDTH+1:2]] = b;
                    end
                end
                OP_BNEZ: begin
                    if (a != '0) begin
                        pc = pc - 4 + (sext << 2);
                    end
                end
                default: begin
                end
            endcase
            steps++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n        <= 1'b0;
        fetch_enable <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic load_word(input int idx, input word_t data);
        @(posedge clk);
        load_we   <= 1'b1;
        load_addr <= ram_idx_t'(idx);
        load_data <= data;
        model_mem[ram_idx_t'(idx)] = data;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            load_word(i, prog[i]);
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    task automatic check_quiet_outputs();
        check_value("exit_valid_o", word_t'(exit_valid), '0);
        check_value("tests_passed_o", word_t'(tests_passed), '0);
        check_value("tests_failed_o", word_t'(tests_failed), '0);
        check_value("exit_value_o", exit_value, '0);
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: mismatch", test_count, name);
        end
    endtask

    task automatic run_test(input string name, input logic has_product, input word_t product);
        int    errs_before;
        int    cycles;
        word_t exp_value;
        logic  model_done;
        errs_before = err_count;
        apply_reset();
        load_program();
        model_run(exp_value, model_done);
        if (!model_done) begin
            $display("the model did not reach the exit store in test %s", name);
            err_count++;
        end
        @(posedge clk);
        fetch_enable <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!exit_valid && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!exit_valid) begin
            $display("timeout: no exit store within %0d cycles in test %s", cycles, name);
            err_count++;
        end else begin
            check_value("exit_value_o", exit_value, exp_value);
            check_value("tests_passed_o", word_t'(tests_passed), word_t'(exp_value == '0));
            check_value("tests_failed_o", word_t'(tests_failed), word_t'(exp_value != '0));
            if (has_product) begin
                check_value("exit_value_o", exit_value, product);
            end
            // the exit pulse lasts one cycle while the value and the flags stay
            @(negedge clk);
            check_value("exit_valid_o", word_t'(exit_valid), '0);
            check_value("exit_value_o", exit_value, exp_value);
            check_value("tests_passed_o", word_t'(tests_passed), word_t'(exp_value == '0));
            check_value("tests_failed_o", word_t'(tests_failed), word_t'(exp_value != '0));
        end
        @(posedge clk);
        fetch_enable <= 1'b0;
        report_test(name, errs_before);
    endtask

    initial begin
        int          errs_before;
        int          count;
        logic [15:0] step;
        void'($urandom(32'h96ae));
        rst_n        <= 1'b1;
        fetch_enable <= 1'b0;
        load_we      <= 1'b0;
        load_addr    <= '0;
        load_data    <= '0;
        apply_reset();
        // each fill word is the index times an odd constant
        for (int i = 0; i < RAM_WORDS; i++) begin
            load_word(i, word_t'(i) * 32'h9e37_79b1);
        end
        @(posedge clk);
        load_we <= 1'b0;

        // a loaded program must not run while fetch enable is low
        errs_before = err_count;
        apply_reset();
        @(negedge clk);
        check_quiet_outputs();
        gen_body(8);
        append_exit(0);
        load_program();
        repeat (200) begin
            @(negedge clk);
            check_quiet_outputs();
        end
        report_test("held core", errs_before);

        repeat (20) begin
            gen_body($urandom_range(24, 4));
            append_exit($urandom_range(2, 0));
            run_test("straight-line", 1'b0, '0);
        end
        repeat (10) begin
            gen_mem_program($urandom_range(6, 2));
            run_test("load/store", 1'b0, '0);
        end
        repeat (6) begin
            count = $urandom_range(50, 1);
            step  = 16'($urandom());
            gen_loop(count, step);
            run_test("countdown loop", 1'b1, word_t'(count) * {{16{step[15]}}, step});
        end
        // r2 minus itself gives a zero exit value
        repeat (4) begin
            gen_body($urandom_range(12, 2));
            prog.push_back(encode_instr(OP_SUB, 2, 2, 2, 16'h0000));
            append_exit(2);
            run_test("zero exit", 1'b0, '0);
        end

        check_value("assertion failures", word_t'(UUT.sva_i.fail_count), '0);
        $display("%0d tests run, %0d failing checks", test_count, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass message in sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_mini_subsystem -f sim.f -o tb_sim > sim.log 2>&1 \
    && ./obj_dir/tb_sim +verilator+error+limit+1000 >> sim.log 2>&1 \
    || echo "build or simulation stopped with an error" >> sim.log

grep -qx "Simulation PASSED" sim.log \
    && echo "simulation passed, see sim.log" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== sim.f ====
+incdir+source
source/mini_pkg.sv
source/mem_bus_if.sv
source/mini_core.sv
source/mm_ram.sv
source/mini_tb_subsystem.sv
bench/mini_subsystem_sva.sv
bench/tb_mini_subsystem.sv

// ==== source/mem_bus_if.sv ====
interface mem_bus_if import mini_pkg::*; ();

    // request, grant and read-valid handshake of one memory port
    logic  req;
    logic  gnt;
    logic  rvalid;
    addr_t addr;
    logic  we;
    word_t wdata;
    word_t rdata;

    // the master holds addr, we and wdata until req and gnt meet
    modport master (
        output req, addr, we, wdata,
        input  gnt, rvalid, rdata
    );

    // the slave answers every accepted transfer with one rvalid pulse
    modport slave (
        input  req, addr, we, wdata,
        output gnt, rvalid, rdata
    );

endinterface

// ==== source/mini_core.sv ====
`include "mini_settings.svh"

module mini_core import mini_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      fetch_enable_i,
    mem_bus_if.master instr_bus,
    mem_bus_if.master data_bus
);

    core_state_e state_q;
    addr_t       pc_q;
    word_t       instr_q;
    word_t       regs_q [4];
    logic        halted_q;

    opcode_t     opcode;
    logic [1:0]  rd;
    logic [1:0]  rs1;
    logic [1:0]  rs2;
    word_t       imm_sext;
    word_t       imm_zext;
    word_t       src_a;
    word_t       src_b;
    word_t       alu_res;
    logic        alu_we;
    logic        is_mem;
    logic        branch_taken;
    addr_t       pc_next;
    addr_t       ls_addr;
    logic        exit_store;

    // instruction fields of the word held in instr_q
    assign opcode   = instr_q[31:28];
    assign rd       = instr_q[27:26];
    assign rs1      = instr_q[25:24];
    assign rs2      = instr_q[23:22];
    assign imm_sext = {{16{instr_q[15]}}, instr_q[15:0]};
    assign imm_zext = {16'h0000, instr_q[15:0]};

    assign src_a = regs_q[rs1];
    assign src_b = regs_q[rs2];

    always_comb begin
        case (opcode)
            OP_LI:   alu_res = imm_sext;
            OP_ADD:  alu_res = src_a + src_b;
            OP_SUB:  alu_res = src_a - src_b;
            OP_XOR:  alu_res = src_a ^ src_b;
            default: alu_res = '0;
        endcase
    end

    assign alu_we = (opcode == OP_LI) || (opcode == OP_ADD) ||
                    (opcode == OP_SUB) || (opcode == OP_XOR);
    assign is_mem = (opcode == OP_LW) || (opcode == OP_SW);

    // branch offset counts in words from the branch itself
    assign branch_taken = (opcode == OP_BNEZ) && (src_a != '0);
    assign pc_next      = branch_taken ? pc_q + {imm_sext[29:0], 2'b00} : pc_q + 32'd4;

    // the load and store address adds the zero-extended immediate to rs1
    assign ls_addr    = imm_zext + src_a;
    assign exit_store = (opcode == OP_SW) && (ls_addr == `MINI_EXIT_ADDR);

    // instruction port only ever reads
    assign instr_bus.req   = (state_q == ST_FETCH);
    assign instr_bus.addr  = pc_q;
    assign instr_bus.we    = 1'b0;
    assign instr_bus.wdata = '0;

    // instr_q and the registers stay put from ST_EXEC until the data rvalid,
    // so the data request fields are stable while req waits for gnt
    assign data_bus.req   = (state_q == ST_DREQ);
    assign data_bus.addr  = ls_addr;
    assign data_bus.we    = (opcode == OP_SW);
    assign data_bus.wdata = src_b;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= ST_IDLE;
            pc_q     <= `MINI_BOOT_ADDR;
            halted_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // once the exit store is done only a reset restarts the core
                    if (fetch_enable_i && !halted_q) begin
                        state_q <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (instr_bus.gnt) begin
                        state_q <= ST_IWAIT;
                    end
                end
                ST_IWAIT: begin
                    if (instr_bus.rvalid) begin
                        state_q <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (is_mem) begin
                        state_q <= ST_DREQ;
                    end else begin
                        pc_q    <= pc_next;
                        state_q <= ST_FETCH;
                    end
                end
                ST_DREQ: begin
                    if (data_bus.gnt) begin
                        state_q <= ST_DWAIT;
                    end
                end
                ST_DWAIT: begin
                    if (data_bus.rvalid) begin
                        pc_q <= pc_next;
                        if (exit_store) begin
                            halted_q <= 1'b1;
                            state_q  <= ST_IDLE;
                        end else begin
                            state_q <= ST_FETCH;
                        end
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // the fetched word is latched when it returns
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IWAIT && instr_bus.rvalid) begin
            instr_q <= instr_bus.rdata;
        end
    end

    // ALU results are written in ST_EXEC and loaded words on the data rvalid
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 4; i++) begin
                regs_q[i] <= '0;
            end
        end else if (state_q == ST_EXEC && alu_we) begin
            regs_q[rd] <= alu_res;
        end else if (state_q == ST_DWAIT && data_bus.rvalid && opcode == OP_LW) begin
            regs_q[rd] <= data_bus.rdata;
        end
    end

endmodule

// ==== source/mini_pkg.sv ====
`include "mini_settings.svh"

package mini_pkg;

    // data word that also holds instruction words and the exit value
    typedef logic [31:0] word_t;

    // byte address on the instruction and data buses
    typedef logic [31:0] addr_t;

    // word index into the RAM array
    typedef logic [`MINI_RAM_ADDR_WIDTH-1:0] ram_idx_t;

    // opcode field in bits 31 to 28 of an instruction
    typedef logic [3:0] opcode_t;

    localparam opcode_t OP_LI   = 4'h1;
    localparam opcode_t OP_ADD  = 4'h2;
    localparam opcode_t OP_SUB  = 4'h3;
    localparam opcode_t OP_XOR  = 4'h4;
    localparam opcode_t OP_LW   = 4'h5;
    localparam opcode_t OP_SW   = 4'h6;
    localparam opcode_t OP_BNEZ = 4'h7;

    // core states for fetching and executing one instruction at a time
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_IWAIT,
        ST_EXEC,
        ST_DREQ,
        ST_DWAIT
    } core_state_e;

endpackage

// ==== source/mini_settings.svh ====
`ifndef MINI_SETTINGS_SVH
`define MINI_SETTINGS_SVH

// number of word address bits of the RAM behind both bus ports
// the RAM holds 2 ** MINI_RAM_ADDR_WIDTH words of 32 bits
`define MINI_RAM_ADDR_WIDTH 10

// byte address of the first instruction after reset
`define MINI_BOOT_ADDR 32'h0000_0000

// a store to this byte address ends the run
// a zero value means passed and anything else means failed
`define MINI_EXIT_ADDR 32'h2000_0000

`endif

// ==== source/mini_tb_subsystem.sv ====
module mini_tb_subsystem import mini_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  logic     fetch_enable_i,

    input  logic     load_we_i,
    input  ram_idx_t load_addr_i,
    input  word_t    load_data_i,

    output logic     tests_passed_o,
    output logic     tests_failed_o,
    output word_t    exit_value_o,
    output logic     exit_valid_o
);

    // instruction fetch and load/store paths between core and memory
    mem_bus_if instr_bus ();
    mem_bus_if data_bus ();

    mini_core core_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .instr_bus      ( instr_bus      ),
        .data_bus       ( data_bus       )
    );

    // RAM plus the memory mapped exit peripheral
    mm_ram ram_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .instr_bus      ( instr_bus      ),
        .data_bus       ( data_bus       ),
        .load_we_i      ( load_we_i      ),
        .load_addr_i    ( load_addr_i    ),
        .load_data_i    ( load_data_i    ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o ),
        .exit_value_o   ( exit_value_o   ),
        .exit_valid_o   ( exit_valid_o   )
    );

endmodule

// ==== source/mm_ram.sv ====
`include "mini_settings.svh"

module mm_ram import mini_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    mem_bus_if.slave instr_bus,
    mem_bus_if.slave data_bus,
    input  logic     load_we_i,
    input  ram_idx_t load_addr_i,
    input  word_t    load_data_i,
    output logic     tests_passed_o,
    output logic     tests_failed_o,
    output word_t    exit_value_o,
    output logic     exit_valid_o
);

    localparam int unsigned RAM_WORDS = 2 ** `MINI_RAM_ADDR_WIDTH;

    word_t    mem [RAM_WORDS];

    logic     instr_acc;
    logic     instr_in_ram;
    ram_idx_t instr_idx;
    logic     instr_rvalid_q;
    word_t    instr_rdata_q;

    logic     data_acc;
    logic     data_in_ram;
    ram_idx_t data_idx;
    logic     data_wr;
    logic     exit_wr;
    logic     data_rvalid_q;
    word_t    data_rdata_q;

    logic     exit_valid_q;
    word_t    exit_value_q;
    logic     passed_q;
    logic     failed_q;

    // both ports reach different words in the same cycle without conflict,
    // so a request is granted at once
    assign instr_bus.gnt = instr_bus.req;
    assign data_bus.gnt  = data_bus.req;

    assign instr_acc = instr_bus.req && instr_bus.gnt;
    assign data_acc  = data_bus.req && data_bus.gnt;

    // a byte address is inside the RAM when all bits above the word index are zero
    assign instr_idx    = instr_bus.addr[`MINI_RAM_ADDR_WIDTH+1:2];
    assign instr_in_ram = (instr_bus.addr[31:`MINI_RAM_ADDR_WIDTH+2] == '0);
    assign data_idx     = data_bus.addr[`MINI_RAM_ADDR_WIDTH+1:2];
    assign data_in_ram  = (data_bus.addr[31:`MINI_RAM_ADDR_WIDTH+2] == '0);

    assign data_wr = data_acc && data_bus.we && data_in_ram;
    assign exit_wr = data_acc && data_bus.we && (data_bus.addr == `MINI_EXIT_ADDR);

    // the load port only runs while the core is held, so it takes priority
    always_ff @(posedge clk_i) begin
        if (load_we_i) begin
            mem[load_addr_i] <= load_data_i;
        end else if (data_wr) begin
            mem[data_idx] <= data_bus.wdata;
        end
    end

    // read data is registered and returned with rvalid one cycle after acceptance
    // unmapped addresses read as zero
    always_ff @(posedge clk_i) begin
        if (instr_acc) begin
            instr_rdata_q <= instr_in_ram ? mem[instr_idx] : '0;
        end
        if (data_acc && !data_bus.we) begin
            data_rdata_q <= data_in_ram ? mem[data_idx] : '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instr_rvalid_q <= 1'b0;
            data_rvalid_q  <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_acc;
            data_rvalid_q  <= data_acc;
        end
    end

    assign instr_bus.rvalid = instr_rvalid_q;
    assign instr_bus.rdata  = instr_rdata_q;
    assign data_bus.rvalid  = data_rvalid_q;
    assign data_bus.rdata   = data_rdata_q;

    // exit pseudo peripheral
    // the valid pulse and the sticky flags appear together, one cycle after the store
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exit_valid_q <= 1'b0;
            exit_value_q <= '0;
            passed_q     <= 1'b0;
            failed_q     <= 1'b0;
        end else begin
            exit_valid_q <= exit_wr;
            if (exit_wr) begin
                exit_value_q <= data_bus.wdata;
                if (data_bus.wdata == '0) begin
                    passed_q <= 1'b1;
                end else begin
                    failed_q <= 1'b1;
                end
            end
        end
    end

    assign exit_valid_o   = exit_valid_q;
    assign exit_value_o   = exit_value_q;
    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;

endmodule
